/* dv/rob_tests.txt */
# one record per line, values in hex, a T line starts a test with its name
# T name | D kind dest | A port tag val | M tag val addr | C tag misp | W t0 v0 t1 v1 mt mv ma | I
T fill_and_wrap
D 0 1
D 0 2
D 0 3
D 0 4
D 0 5
D 0 6
D 0 7
D 0 8
I
W 2 22 1 11 3 33 0
A 1 5 55
A 0 4 44
A 0 7 77
A 1 6 66
I
I
I
T out_of_order
D 0 a
D 0 b
D 0 c
A 0 3 c3
A 1 2 b2
I
A 0 1 a1
I
I
I
T store_and_load
D 1 ffff
D 0 5
M 5 1234 0
M 4 beef 100
I
I
T branches
D 2 0
D 2 0
D 0 9
C 6 0
A 0 1 99
C 7 1
D 0 4
D 0 3
A 0 1 31
I

/* filelist.f */
+incdir+.
design/rob_pkg.sv
design/rob_dispatch.sv
design/rob_entries.sv
design/rob_commit.sv
design/reorder_buffer.sv
dv/rob_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the reorder buffer testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module rob_tb -Mdir obj_dir -o rob_sim

# the simulator exits cleanly either way, the log decides
./obj_dir/rob_sim | tee sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation result: pass"
    exit 0
fi

echo "simulation result: fail"
exit 1

/* dv/rob_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rob_config.svh"

// testbench for the reorder buffer
// records from dv/rob_tests.txt drive the dut while an in-order model predicts every output
module rob_tb
    import rob_pkg::*;
();

    localparam int DEPTH = `ROB_DEPTH;
    localparam int PORTS = `NUM_ALU_PORTS;

    logic             clk;
    logic             reset;
    logic             valid_in;
    op_kind_t         op_kind;
    rob_dest_u        dest;
    logic [PORTS-1:0] alu_valid;
    tag_t             alu_tag [PORTS];
    word_t            alu_val [PORTS];
    logic             mem_valid;
    tag_t             mem_tag;
    word_t            mem_val;
    word_t            mem_addr;
    logic             cmp_valid;
    tag_t             cmp_tag;
    logic             cmp_mispredict;
    tag_t             alloc_tag;
    logic             full;
    logic             reg_write;
    logic [4:0]       reg_rd;
    tag_t             reg_tag;
    word_t            reg_val;
    logic             mem_write;
    word_t            mem_address;
    word_t            mem_wdata;
    logic             flush;

    // model state with program order kept as a queue of tags
    logic     m_busy  [DEPTH];
    logic     m_ready [DEPTH];
    logic     m_misp  [DEPTH];
    op_kind_t m_kind  [DEPTH];
    word_t    m_dest  [DEPTH];
    word_t    m_val   [DEPTH];
    tag_t     m_order [$];
    tag_t     m_in_ptr;

    string  records [$];
    bit     records_loaded;
    integer seed;
    int     errors;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    string  test_name;
    int     watchdog_limit;

    reorder_buffer dut_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic load_records();
        int    fd;
        string line;
        fd = $fopen("dv/rob_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/rob_tests.txt for reading");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // strip the line ending
                while (line.len() > 0 && (line.getc(line.len() - 1) == "\n"
                       || line.getc(line.len() - 1) == "\r")) begin
                    line = line.substr(0, line.len() - 2);
                end
                // blank and comment lines hold no record
                if (line.len() > 0 && line.getc(0) != "#") begin
                    records.push_back(line);
                end
            end
            $fclose(fd);
        end
        records_loaded = 1'b1;
    endtask

    // empty buffer with both pointers on the first usable entry
    task automatic clear_model();
        m_busy   = '{default: 1'b0};
        m_ready  = '{default: 1'b0};
        m_misp   = '{default: 1'b0};
        m_kind   = '{default: OP_REG};
        m_dest   = '{default: '0};
        m_val    = '{default: '0};
        m_order.delete();
        m_in_ptr = tag_t'(1);
    endtask

    // oldest entry has its result in and leaves this cycle
    function automatic logic head_retires();
        return m_order.size() > 0 && m_ready[m_order[0]];
    endfunction

    task automatic drive_record(input string rec);
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        int    f;
        int    g;
        string fields;
        // noise on every field while valid bits stay low unless the record sets one
        op_kind = op_kind_t'(2'($random(seed)));
        dest.addr = $random(seed);
        for (int i = 0; i < PORTS; i++) begin
            alu_tag[i] = tag_t'($random(seed));
            alu_val[i] = $random(seed);
        end
        mem_tag        = tag_t'($random(seed));
        mem_val        = $random(seed);
        mem_addr       = $random(seed);
        cmp_tag        = tag_t'($random(seed));
        cmp_mispredict = 1'($random(seed));
        valid_in       = 1'b0;
        alu_valid      = '0;
        mem_valid      = 1'b0;
        cmp_valid      = 1'b0;
        fields = rec.substr(1, rec.len() - 1);
        void'($sscanf(fields, "%h %h %h %h %h %h %h", a, b, c, d, e, f, g));
        case (rec.getc(0))
            "D": begin
                valid_in  = 1'b1;
                op_kind   = op_kind_t'(a[1:0]);
                dest.addr = word_t'(b);
            end
            "A": begin
                for (int i = 0; i < PORTS; i++) begin
                    if (i == a) begin
                        alu_valid[i] = 1'b1;
                        alu_tag[i]   = tag_t'(b);
                        alu_val[i]   = word_t'(c);
                    end
                end
            end
            "M": begin
                mem_valid = 1'b1;
                mem_tag   = tag_t'(a);
                mem_val   = word_t'(b);
                mem_addr  = word_t'(c);
            end
            "C": begin
                cmp_valid      = 1'b1;
                cmp_tag        = tag_t'(a);
                cmp_mispredict = 1'(b);
            end
            "W": begin
                // two alu ports and the memory port in one cycle
                alu_valid[0] = 1'b1;
                alu_tag[0]   = tag_t'(a);
                alu_val[0]   = word_t'(b);
                alu_valid[1] = 1'b1;
                alu_tag[1]   = tag_t'(c);
                alu_val[1]   = word_t'(d);
                mem_valid    = 1'b1;
                mem_tag      = tag_t'(e);
                mem_val      = word_t'(f);
                mem_addr     = word_t'(g);
            end
            "I": begin
                // noise only with no strobe
            end
            default: begin
                $display("unknown record kind in line: %s", rec);
                errors++;
                test_errors++;
            end
        endcase
    endtask

    // outputs are combinational from state, so the model state predicts them
    task automatic check_outputs();
        tag_t h;
        logic retire;
        logic exp_reg;
        logic exp_mem;
        logic exp_flush;
        retire    = head_retires();
        h         = retire ? m_order[0] : tag_t'(0);
        exp_reg   = retire && m_kind[h] == OP_REG;
        exp_mem   = retire && m_kind[h] == OP_ST;
        exp_flush = retire && m_kind[h] == OP_BR && m_misp[h];
        check_value("alloc_tag", 32'(m_in_ptr), 32'(alloc_tag));
        check_value("full", 32'(m_order.size() == DEPTH - 1), 32'(full));
        check_value("reg_write", 32'(exp_reg), 32'(reg_write));
        check_value("mem_write", 32'(exp_mem), 32'(mem_write));
        check_value("flush", 32'(exp_flush), 32'(flush));
        if (exp_reg) begin
            check_value("reg_rd", 32'(m_dest[h][4:0]), 32'(reg_rd));
            check_value("reg_tag", 32'(h), 32'(reg_tag));
            check_value("reg_val", m_val[h], reg_val);
        end
        if (exp_mem) begin
            check_value("mem_address", m_dest[h], mem_address);
            check_value("mem_wdata", m_val[h], mem_wdata);
        end
    endtask

    // state after the coming edge from the inputs held this cycle
    task automatic advance_model();
        tag_t h;
        logic retire;
        logic was_full;
        retire   = head_retires();
        h        = retire ? m_order[0] : tag_t'(0);
        was_full = m_order.size() == DEPTH - 1;
        if (retire && m_kind[h] == OP_BR && m_misp[h]) begin
            // results and the dispatch of this cycle are lost too
            clear_model();
        end else begin
            for (int i = 0; i < PORTS; i++) begin
                if (alu_valid[i] && m_busy[alu_tag[i]]) begin
                    m_val[alu_tag[i]]   = alu_val[i];
                    m_ready[alu_tag[i]] = 1'b1;
                end
            end
            if (mem_valid && m_busy[mem_tag] && m_kind[mem_tag] != OP_BR) begin
                m_val[mem_tag]   = mem_val;
                m_ready[mem_tag] = 1'b1;
                if (m_kind[mem_tag] == OP_ST) begin
                    m_dest[mem_tag] = mem_addr;
                end
            end
            if (cmp_valid && m_busy[cmp_tag]) begin
                m_ready[cmp_tag] = 1'b1;
                m_misp[cmp_tag]  = cmp_mispredict;
            end
            if (retire) begin
                void'(m_order.pop_front());
                m_busy[h]  = 1'b0;
                m_ready[h] = 1'b0;
                m_misp[h]  = 1'b0;
            end
            // tags run 1 .. DEPTH-1 and skip 0
            if (valid_in && !was_full) begin
                m_order.push_back(m_in_ptr);
                m_busy[m_in_ptr]  = 1'b1;
                m_ready[m_in_ptr] = 1'b0;
                m_misp[m_in_ptr]  = 1'b0;
                m_kind[m_in_ptr]  = op_kind;
                m_dest[m_in_ptr]  = dest.addr;
                m_in_ptr = (m_in_ptr == tag_t'(DEPTH - 1)) ? tag_t'(1) : m_in_ptr + tag_t'(1);
            end
        end
    endtask

    task automatic finish_test();
        if (test_name != "") begin
            tests_run++;
            if (test_errors == 0) begin
                $display("test %s: ok", test_name);
            end else begin
                tests_failed++;
                $display("test %s: %0d errors", test_name, test_errors);
            end
        end
        test_errors = 0;
    endtask

    initial begin
        seed           = 32'h267f;
        errors         = 0;
        test_errors    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_name      = "";
        reset          = 1'b1;
        valid_in       = 1'b0;
        op_kind        = OP_REG;
        dest           = '0;
        alu_valid      = '0;
        alu_tag        = '{default: '0};
        alu_val        = '{default: '0};
        mem_valid      = 1'b0;
        mem_tag        = '0;
        mem_val        = '0;
        mem_addr       = '0;
        cmp_valid      = 1'b0;
        cmp_tag        = '0;
        cmp_mispredict = 1'b0;
        load_records();
        clear_model();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (records[r]) begin
            if (records[r].getc(0) == "T") begin
                finish_test();
                test_name = records[r].substr(2, records[r].len() - 1);
            end else begin
                @(posedge clk);
                #1;
                drive_record(records[r]);
                // inputs and outputs are settled by mid cycle
                @(negedge clk);
                check_outputs();
                advance_model();
            end
        end
        finish_test();
        if (tests_run == 0) begin
            $display("no tests were found in the record file");
            errors++;
        end
        $display("tests run %0d, tests failing %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // limit grows with the number of records plus slack for reset
    initial begin
        wait (records_loaded);
        watchdog_limit = (records.size() + 50) * 100;
        #(watchdog_limit);
        $display("watchdog expired at %0t, the tests did not finish in time", $time);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* design/reorder_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rob_config.svh"

// reorder buffer top
// dispatch side, entry storage and commit side
module reorder_buffer
    import rob_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      reset,
    // from the decoder
    input  wire logic                      valid_in,
    input  wire op_kind_t                  op_kind,
    input  wire rob_dest_u                 dest,
    // result buses
    input  wire logic [`NUM_ALU_PORTS-1:0] alu_valid,
    input  wire tag_t                      alu_tag [`NUM_ALU_PORTS],
    input  wire word_t                     alu_val [`NUM_ALU_PORTS],
    input  wire logic                      mem_valid,
    input  wire tag_t                      mem_tag,
    input  wire word_t                     mem_val,
    input  wire word_t                     mem_addr,
    input  wire logic                      cmp_valid,
    input  wire tag_t                      cmp_tag,
    input  wire logic                      cmp_mispredict,
    // to the decoder
    output tag_t                           alloc_tag,
    output logic                           full,
    // to the register file
    output logic                           reg_write,
    output logic [4:0]                     reg_rd,
    output tag_t                           reg_tag,
    output word_t                          reg_val,
    // to the memory unit
    output logic                           mem_write,
    output word_t                          mem_address,
    output word_t                          mem_wdata,
    output logic                           flush
);

    logic                  dispatch_en;
    tag_t                  in_tag;
    logic [`ROB_DEPTH-1:0] busy;
    logic                  commit_en;
    tag_t                  head_tag;
    logic                  head_ready;
    op_kind_t              head_kind;
    rob_dest_u             head_dest;
    word_t                 head_val;
    logic                  head_mispredict;

    rob_dispatch dispatch_i (
        .clk, .reset, .valid_in, .busy, .flush,
        .dispatch_en, .in_tag, .alloc_tag, .full
    );

    rob_entries entries_i (
        .clk, .reset, .flush, .dispatch_en, .in_tag, .op_kind, .dest,
        .alu_valid, .alu_tag, .alu_val,
        .mem_valid, .mem_tag, .mem_val, .mem_addr,
        .cmp_valid, .cmp_tag, .cmp_mispredict,
        .commit_en, .head_tag, .busy,
        .head_ready, .head_kind, .head_dest, .head_val, .head_mispredict
    );

    rob_commit commit_i (
        .clk, .reset,
        .head_ready, .head_kind, .head_dest, .head_val, .head_mispredict,
        .commit_en, .head_tag,
        .reg_write, .reg_rd, .reg_tag, .reg_val,
        .mem_write, .mem_address, .mem_wdata, .flush
    );

endmodule

`default_nettype wire

/* design/rob_commit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rob_config.svh"

// output side of the reorder buffer
// retires the head entry in program order, one per cycle
module rob_commit
    import rob_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    // head entry from the storage
    input  wire logic      head_ready,
    input  wire op_kind_t  head_kind,
    input  wire rob_dest_u head_dest,
    input  wire word_t     head_val,
    input  wire logic      head_mispredict,
    // retirement strobe and index back to the storage
    output logic           commit_en,
    output tag_t           head_tag,
    // register file write
    output logic           reg_write,
    output logic [4:0]     reg_rd,
    output tag_t           reg_tag,
    output word_t          reg_val,
    // memory unit write
    output logic           mem_write,
    output word_t          mem_address,
    output word_t          mem_wdata,
    // mispredicted branch at the head
    output logic           flush
);

    // oldest entry still in flight
    tag_t head_ptr;

    assign head_tag = head_ptr;

    // the head retires as soon as its result is in
    assign commit_en = head_ready;

    // decode the head by kind
    always_comb begin
        reg_write   = 1'b0;
        reg_rd      = '0;
        reg_tag     = '0;
        reg_val     = '0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        flush       = 1'b0;
        if (head_ready) begin
            case (head_kind)
                OP_REG: begin
                    // loads come through here too
                    reg_write = 1'b1;
                    reg_rd    = head_dest.rd.idx;
                    reg_tag   = head_ptr;
                    reg_val   = head_val;
                end
                OP_ST: begin
                    mem_write   = 1'b1;
                    mem_address = head_dest.addr;
                    mem_wdata   = head_val;
                end
                OP_BR: begin
                    // a correct branch leaves without any strobe
                    flush = head_mispredict;
                end
                default: begin
                    // kind 3 is never dispatched
                end
            endcase
        end
    end

    // commit pointer
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_ptr <= tag_t'(`ROB_FIRST_TAG);
        end else if (commit_en) begin
            head_ptr <= next_tag(head_ptr);
        end
    end

endmodule

`default_nettype wire

/* design/rob_entries.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rob_config.svh"

// entry storage of the reorder buffer
// filled from dispatch and from the result buses, drained at the head
module rob_entries
    import rob_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     flush,
    // dispatch write
    input  wire logic                     dispatch_en,
    input  wire tag_t                     in_tag,
    input  wire op_kind_t                 op_kind,
    input  wire rob_dest_u                dest,
    // alu result buses
    input  wire logic [`NUM_ALU_PORTS-1:0] alu_valid,
    input  wire tag_t                     alu_tag [`NUM_ALU_PORTS],
    input  wire word_t                    alu_val [`NUM_ALU_PORTS],
    // memory result bus
    input  wire logic                     mem_valid,
    input  wire tag_t                     mem_tag,
    input  wire word_t                    mem_val,
    input  wire word_t                    mem_addr,
    // compare result bus
    input  wire logic                     cmp_valid,
    input  wire tag_t                     cmp_tag,
    input  wire logic                     cmp_mispredict,
    // retirement of the head entry
    input  wire logic                     commit_en,
    input  wire tag_t                     head_tag,
    // occupancy for the dispatch side
    output logic [`ROB_DEPTH-1:0]         busy,
    // head entry as seen by commit
    output logic                          head_ready,
    output op_kind_t                      head_kind,
    output rob_dest_u                     head_dest,
    output word_t                         head_val,
    output logic                          head_mispredict
);

    // control bits per entry
    logic [`ROB_DEPTH-1:0] busy_q;
    logic [`ROB_DEPTH-1:0] ready_q;
    logic [`ROB_DEPTH-1:0] misp_q;

    // payload per entry
    op_kind_t  kind_q [`ROB_DEPTH];
    rob_dest_u dest_q [`ROB_DEPTH];
    word_t     val_q  [`ROB_DEPTH];

    // result strobes that land on a live entry
    logic [`NUM_ALU_PORTS-1:0] alu_hit;
    logic                      mem_hit;
    logic                      cmp_hit;

    always_comb begin
        for (int i = 0; i < `NUM_ALU_PORTS; i++) begin
            alu_hit[i] = alu_valid[i] && busy_q[alu_tag[i]];
        end
        // the memory port only completes loads and stores
        mem_hit = mem_valid && busy_q[mem_tag]
                  && (kind_q[mem_tag] == OP_REG || kind_q[mem_tag] == OP_ST);
        cmp_hit = cmp_valid && busy_q[cmp_tag];
    end

    // busy, ready and mispredict bits
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            // empty the whole buffer and drop the results of this cycle
            busy_q  <= '0;
            ready_q <= '0;
            misp_q  <= '0;
        end else begin
            if (dispatch_en) begin
                busy_q[in_tag]  <= 1'b1;
                ready_q[in_tag] <= 1'b0;
                misp_q[in_tag]  <= 1'b0;
            end
            for (int i = 0; i < `NUM_ALU_PORTS; i++) begin
                if (alu_hit[i]) begin
                    ready_q[alu_tag[i]] <= 1'b1;
                end
            end
            if (mem_hit) begin
                ready_q[mem_tag] <= 1'b1;
            end
            if (cmp_hit) begin
                ready_q[cmp_tag] <= 1'b1;
                // acted on only when the branch reaches the head
                misp_q[cmp_tag]  <= cmp_mispredict;
            end
            // retiring entry is freed for the dispatch side
            if (commit_en) begin
                busy_q[head_tag]  <= 1'b0;
                ready_q[head_tag] <= 1'b0;
                misp_q[head_tag]  <= 1'b0;
            end
        end
    end

    // kind, destination and value
    always_ff @(posedge clk) begin
        if (dispatch_en) begin
            kind_q[in_tag] <= op_kind;
            dest_q[in_tag] <= dest;
        end
        for (int i = 0; i < `NUM_ALU_PORTS; i++) begin
            if (alu_hit[i]) begin
                val_q[alu_tag[i]] <= alu_val[i];
            end
        end
        if (mem_hit) begin
            // load value or store data
            val_q[mem_tag] <= mem_val;
            // a store learns its address only now
            if (kind_q[mem_tag] == OP_ST) begin
                dest_q[mem_tag].addr <= mem_addr;
            end
        end
    end

    assign busy = busy_q;

    // head entry fields
    assign head_ready      = ready_q[head_tag];
    assign head_kind       = kind_q[head_tag];
    assign head_dest       = dest_q[head_tag];
    assign head_val        = val_q[head_tag];
    assign head_mispredict = misp_q[head_tag];

endmodule

`default_nettype wire

/* design/rob_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rob_config.svh"

// input side of the reorder buffer
// keeps the allocation pointer and reports full back to the decoder
module rob_dispatch
    import rob_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    // strobe from the decoder
    input  wire logic                  valid_in,
    // occupancy of every entry
    input  wire logic [`ROB_DEPTH-1:0] busy,
    // mispredicted branch retiring this cycle
    input  wire logic                  flush,
    // write enable and index into the entry storage
    output logic                       dispatch_en,
    output tag_t                       in_tag,
    // to the decoder
    output tag_t                       alloc_tag,
    output logic                       full
);

    // next entry waiting for an instruction
    tag_t in_ptr;

    // the buffer is full once the pointer lands on an entry
    // that has not retired yet
    assign full = busy[in_ptr];

    // a strobe while full is dropped and the decoder holds the instruction
    assign dispatch_en = valid_in && !full;

    // the storage writes at the same index the decoder sees
    assign in_tag    = in_ptr;
    assign alloc_tag = in_ptr;

    // pointer walks 1 .. ROB_DEPTH-1 and wraps back to 1
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            in_ptr <= tag_t'(`ROB_FIRST_TAG);
        end else if (dispatch_en) begin
            in_ptr <= next_tag(in_ptr);
        end
    end

endmodule

`default_nettype wire

/* design/rob_pkg.sv */
`default_nettype none

package rob_pkg;

`include "rob_config.svh"

    // tag width follows the entry count
    localparam int TAG_W = $clog2(`ROB_DEPTH);

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [31:0] word_t;

    // what the entry does when it reaches the head
    typedef enum logic [1:0] {
        OP_REG = 2'd0,
        OP_ST  = 2'd1,
        OP_BR  = 2'd2
    } op_kind_t;

    // destination word of an entry
    // register ops read the low five bits, stores read the full address
    typedef union packed {
        struct packed {
            logic [26:0] pad;
            logic [4:0]  idx;
        } rd;
        word_t addr;
    } rob_dest_u;

    // step a pointer and skip entry 0 on wrap
    function automatic tag_t next_tag(input tag_t t);
        if (t == tag_t'(`ROB_DEPTH - 1)) begin
            return tag_t'(`ROB_FIRST_TAG);
        end
        return t + tag_t'(1);
    endfunction

endpackage

`default_nettype wire

/* rob_config.svh */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// sizing of the reorder buffer subsystem

// number of entries including entry 0
// entry 0 stays empty so that tag 0 can mean no tag
// must be a power of two so the tag field wraps cleanly
`define ROB_DEPTH 8

// number of alu result buses feeding the buffer
`define NUM_ALU_PORTS 2

// tag of the first usable entry
// pointers return here on reset and on flush
`define ROB_FIRST_TAG 1

`endif
